// File: Makefile
# Verilator build and run for the aggregating pipeline

TOP       ?= aggregatingPipelineTb
SEED      ?= 79
LOG       ?= sim.log
FILELIST  ?= aggregatingPipeline.f
BUILD     ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and judge the result from $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"
	@echo "Variables: TOP=$(TOP) SEED=$(SEED) LOG=$(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSeed=$(SEED) \
		-f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "test FAILED"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "test FAILED, no verdict"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: aggregatingPipeline.f
logic/agPkg.sv
logic/graphIf.sv
logic/topReceiver.sv
logic/leafEliminator.sv
logic/componentCounter.sv
logic/pcoeffAccumulator.sv
logic/aggregatingPipeline.sv
test/tbClock.sv
test/pipelineChecker.sv
test/aggregatingPipelineTb.sv

// File: logic/agPkg.sv
package agPkg;

    localparam int Dim = 7;                 // hypercube dimension
    localparam int NodeCount = 1 << Dim;    // 128 nodes
    localparam int CountWidth = 7;          // component count reaches 64
    localparam int MaxValidCount = 35;
    localparam int PcoeffBits = 36;         // one 2**count term

    typedef logic [NodeCount-1:0] graphT;   // one graph or node set

    // set of all nodes that sit next to at least one member of s
    function automatic graphT neighbours(graphT s);
        graphT n;
        n = '0;
        for (int d = 0; d < Dim; d++) begin
            for (int i = 0; i < NodeCount; i++) begin
                if (s[i ^ (1 << d)]) begin
                    n[i] = 1'b1;
                end
            end
        end
        return n;
    endfunction

    // isolate the lowest set node, zero if s is empty
    function automatic graphT lowestNode(graphT s);
        return s & (~s + 1'b1);
    endfunction

endpackage

// File: logic/aggregatingPipeline.sv
`timescale 1ns/1ps

module aggregatingPipeline #(
    parameter int PcoeffCountWidth = 10,
    parameter int FifoDepth = 8
) (
    input  logic clk,
    input  logic rstN,
    input  logic longRst,
    input  logic [1:0] topChannel,
    input  logic botValid,
    input  agPkg::graphT bot,
    input  logic lastBotOfBatch,
    output logic slowDown,
    output logic resultsValid,
    output logic [PcoeffCountWidth+agPkg::PcoeffBits-1:0] pcoeffSum,
    output logic [PcoeffCountWidth-1:0] pcoeffCount,
    output logic errorFlag
);

    agPkg::graphT top;
    logic badBot;
    logic countValid;
    logic [agPkg::CountWidth-1:0] count;
    logic countLast;
    logic countError;

    graphIf gIf ();

    topReceiver receiver (
        .clk        (clk),
        .rstN       (rstN),
        .topChannel (topChannel),
        .top        (top)
    );

    leafEliminator eliminator (
        .clk            (clk),
        .rstN           (rstN),
        .top            (top),
        .botValid       (botValid),
        .bot            (bot),
        .lastBotOfBatch (lastBotOfBatch),
        .badBot         (badBot),
        .out            (gIf.source)
    );

    componentCounter #(
        .FifoDepth (FifoDepth)
    ) counter (
        .clk        (clk),
        .rstN       (rstN),
        .in         (gIf.sink),
        .countValid (countValid),
        .count      (count),
        .countLast  (countLast)
    );

    pcoeffAccumulator #(
        .PcoeffCountWidth (PcoeffCountWidth)
    ) accumulator (
        .clk          (clk),
        .rstN         (rstN),
        .longRst      (longRst),
        .countValid   (countValid),
        .count        (count),
        .countLast    (countLast),
        .resultsValid (resultsValid),
        .pcoeffSum    (pcoeffSum),
        .pcoeffCount  (pcoeffCount),
        .countError   (countError)
    );

    assign slowDown = gIf.slowDown;

    // sticky until the next hard reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            errorFlag <= 1'b0;
        end else if (badBot || countError) begin
            errorFlag <= 1'b1;
        end
    end

endmodule

// File: logic/componentCounter.sv
`timescale 1ns/1ps

module componentCounter #(
    parameter int FifoDepth = 8
) (
    input  logic clk,
    input  logic rstN,
    graphIf.sink in,
    output logic countValid,
    output logic [agPkg::CountWidth-1:0] count,
    output logic countLast
);

    localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
    localparam int FillWidth = $clog2(FifoDepth + 1);

    typedef enum logic [1:0] {
        Idle,
        Seed,
        Grow
    } stateT;

    agPkg::graphT fifoGraph [FifoDepth];
    logic fifoLast [FifoDepth];
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic [FillWidth-1:0] fill;
    logic push;
    logic pop;

    stateT state;
    agPkg::graphT remaining;    // nodes not yet assigned to a component
    agPkg::graphT frontier;     // current component as grown so far
    agPkg::graphT grown;
    logic [agPkg::CountWidth-1:0] compCount;
    logic lastTag;

    function automatic logic [PtrWidth-1:0] nextPtr(logic [PtrWidth-1:0] p);
        return (p == PtrWidth'(FifoDepth - 1)) ? '0 : p + 1'b1;
    endfunction

    // input FIFO
    assign push = in.valid && (fill != FillWidth'(FifoDepth));  // full drops, advisory only
    assign pop = (state == Idle) && (fill != '0);

    // fewer than 4 free entries: two graphs in flight plus one spare
    assign in.slowDown = int'(fill) > FifoDepth - 4;

    always_ff @(posedge clk) begin
        if (push) begin
            fifoGraph[wrPtr] <= in.graph;
            fifoLast[wrPtr] <= in.last;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            if (push && !pop) begin
                fill <= fill + 1'b1;
            end else if (pop && !push) begin
                fill <= fill - 1'b1;
            end
        end
    end

    // flood fill: one hypercube step per cycle, restricted to what is left
    assign grown = (frontier | agPkg::neighbours(frontier)) & remaining;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= Idle;
            remaining <= '0;
            frontier <= '0;
            compCount <= '0;
            lastTag <= 1'b0;
            countValid <= 1'b0;
            count <= '0;
            countLast <= 1'b0;
        end else begin
            countValid <= 1'b0;
            case (state)
                Idle: begin
                    if (pop) begin
                        remaining <= fifoGraph[rdPtr];
                        lastTag <= fifoLast[rdPtr];
                        compCount <= '0;
                        state <= Seed;
                    end
                end
                Seed: begin
                    if (remaining == '0) begin
                        countValid <= 1'b1;     // empty graph gives 0
                        count <= compCount;
                        countLast <= lastTag;
                        state <= Idle;
                    end else begin
                        frontier <= agPkg::lowestNode(remaining);
                        state <= Grow;
                    end
                end
                Grow: begin
                    if (grown == frontier) begin
                        // component closed, strip it and reseed
                        remaining <= remaining & ~frontier;
                        compCount <= compCount + 1'b1;
                        state <= Seed;
                    end else begin
                        frontier <= grown;
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

endmodule

// File: logic/graphIf.sv
`timescale 1ns/1ps

interface graphIf;

    logic valid;            // one-cycle strobe per graph
    agPkg::graphT graph;
    logic last;             // last graph of the batch
    logic slowDown;         // advisory back-pressure from the counter

    modport source (
        output valid,
        output graph,
        output last,
        input  slowDown
    );

    modport sink (
        input  valid,
        input  graph,
        input  last,
        output slowDown
    );

endinterface

// File: logic/leafEliminator.sv
`timescale 1ns/1ps

module leafEliminator (
    input  logic clk,
    input  logic rstN,
    input  agPkg::graphT top,
    input  logic botValid,
    input  agPkg::graphT bot,
    input  logic lastBotOfBatch,
    output logic badBot,
    graphIf.source out
);

    agPkg::graphT graphD;
    logic validD;
    logic lastD;

    agPkg::graphT pruned;
    logic [2:0] nbrCount;
    logic downOnly;

    // stage one
    always_ff @(posedge clk) begin
        graphD <= top & ~bot;
        lastD <= lastBotOfBatch;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validD <= 1'b0;
            badBot <= 1'b0;
        end else begin
            validD <= botValid;
            badBot <= botValid && ((bot & ~top) != '0);  // bot must be a subset of top
        end
    end

    // a node whose single neighbour lies below it is a DOWN leaf
    // in an isolated pair only the upper node goes, so counts hold
    always_comb begin
        pruned = graphD;
        nbrCount = '0;
        downOnly = 1'b1;
        for (int i = 0; i < agPkg::NodeCount; i++) begin
            nbrCount = '0;
            downOnly = 1'b1;
            for (int d = 0; d < agPkg::Dim; d++) begin
                if (graphD[i ^ (1 << d)]) begin
                    nbrCount = nbrCount + 1'b1;
                    if (((i >> d) & 1) == 0) begin
                        downOnly = 1'b0;    // neighbour is above
                    end
                end
            end
            if (nbrCount == 3'd1 && downOnly) begin
                pruned[i] = 1'b0;
            end
        end
    end

    // stage two
    always_ff @(posedge clk) begin
        out.graph <= pruned;
        out.last <= lastD;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= validD;
        end
    end

endmodule

// File: logic/pcoeffAccumulator.sv
`timescale 1ns/1ps

module pcoeffAccumulator #(
    parameter int PcoeffCountWidth = 10
) (
    input  logic clk,
    input  logic rstN,
    input  logic longRst,
    input  logic countValid,
    input  logic [agPkg::CountWidth-1:0] count,
    input  logic countLast,
    output logic resultsValid,
    output logic [PcoeffCountWidth+agPkg::PcoeffBits-1:0] pcoeffSum,
    output logic [PcoeffCountWidth-1:0] pcoeffCount,
    output logic countError
);

    localparam int SumWidth = PcoeffCountWidth + agPkg::PcoeffBits;

    logic [SumWidth-1:0] runSum;
    logic [PcoeffCountWidth-1:0] runCount;
    logic [agPkg::PcoeffBits-1:0] term;
    logic inRange;
    logic [SumWidth-1:0] newSum;
    logic [PcoeffCountWidth-1:0] newCount;
    logic publish;

    assign inRange = (count <= agPkg::MaxValidCount);
    assign term = inRange ? (agPkg::PcoeffBits'(1) << count) : '0;  // out of range adds nothing
    assign newSum = runSum + SumWidth'(term);
    assign newCount = runCount + 1'b1;
    assign publish = countValid && countLast && !longRst;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            runSum <= '0;
            runCount <= '0;
            resultsValid <= 1'b0;
            countError <= 1'b0;
        end else begin
            resultsValid <= publish;
            countError <= countValid && !inRange;
            if (longRst || publish) begin
                runSum <= '0;   // batch closed or discarded
                runCount <= '0;
            end else if (countValid) begin
                runSum <= newSum;
                runCount <= newCount;
            end
        end
    end

    // final totals include the closing term
    always_ff @(posedge clk) begin
        if (publish) begin
            pcoeffSum <= newSum;
            pcoeffCount <= newCount;
        end
    end

endmodule

// File: logic/topReceiver.sv
`timescale 1ns/1ps

module topReceiver (
    input  logic clk,
    input  logic rstN,
    input  logic [1:0] topChannel,      // [1] strobe, [0] data
    output agPkg::graphT top
);

    agPkg::graphT shiftReg;
    logic [agPkg::Dim-1:0] strobeCnt;
    logic strobe;
    logic lastBit;

    assign strobe = topChannel[1];
    assign lastBit = (strobeCnt == '1);    // 128th strobe of the word

    // lsb arrives first, so new bits enter from the top end
    always_ff @(posedge clk) begin
        if (strobe) begin
            shiftReg <= {topChannel[0], shiftReg[agPkg::NodeCount-1:1]};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            strobeCnt <= '0;
            top <= '0;
        end else if (strobe) begin
            strobeCnt <= strobeCnt + 1'b1;  // wraps to zero for the next word
            if (lastBit) begin
                // publish only the complete word
                top <= {topChannel[0], shiftReg[agPkg::NodeCount-1:1]};
            end
        end
    end

endmodule

// File: test/aggregatingPipelineTb.sv
`timescale 1ns/1ps

module aggregatingPipelineTb;

    parameter int Seed = 79;

    localparam int PcoeffCountWidth = 10;
    localparam int FifoDepth = 8;
    localparam int SumWidth = PcoeffCountWidth + agPkg::PcoeffBits;
    localparam int CyclesPerBot = 300;      // worst-case flood fill is well below this
    localparam int MaxBots = 100;
    localparam int TopLoads = 7;
    localparam int TopLoadCycles = agPkg::NodeCount + 2;
    localparam int DrainBots = 3;
    localparam int WatchdogCycles = MaxBots * CyclesPerBot + TopLoads * TopLoadCycles
                                    + DrainBots * CyclesPerBot + 1000;

    logic clk;
    logic rstN;
    logic rstReq;
    logic longRst;
    logic [1:0] topChannel;
    logic botValid;
    agPkg::graphT bot;
    logic lastBotOfBatch;
    logic slowDown;
    logic resultsValid;
    logic [SumWidth-1:0] pcoeffSum;
    logic [PcoeffCountWidth-1:0] pcoeffCount;
    logic errorFlag;
    logic finalCheck;
    int resultsSeen;
    int valueErrors;
    int otherErrors;
    int batchesSent;
    agPkg::graphT curTop;

    tbClock clockGen (.rstReq(rstReq), .clk(clk), .rstN(rstN));

    aggregatingPipeline #(
        .PcoeffCountWidth (PcoeffCountWidth),
        .FifoDepth        (FifoDepth)
    ) i_dut (
        .clk            (clk),
        .rstN           (rstN),
        .longRst        (longRst),
        .topChannel     (topChannel),
        .botValid       (botValid),
        .bot            (bot),
        .lastBotOfBatch (lastBotOfBatch),
        .slowDown       (slowDown),
        .resultsValid   (resultsValid),
        .pcoeffSum      (pcoeffSum),
        .pcoeffCount    (pcoeffCount),
        .errorFlag      (errorFlag)
    );

    pipelineChecker #(
        .PcoeffCountWidth (PcoeffCountWidth)
    ) monitor (
        .clk            (clk),
        .rstN           (rstN),
        .longRst        (longRst),
        .topChannel     (topChannel),
        .botValid       (botValid),
        .bot            (bot),
        .lastBotOfBatch (lastBotOfBatch),
        .slowDown       (slowDown),
        .resultsValid   (resultsValid),
        .pcoeffSum      (pcoeffSum),
        .pcoeffCount    (pcoeffCount),
        .errorFlag      (errorFlag),
        .finalCheck     (finalCheck),
        .resultsSeen    (resultsSeen),
        .valueErrors    (valueErrors),
        .otherErrors    (otherErrors)
    );

    function automatic agPkg::graphT nodeBit(int n);
        return agPkg::graphT'(1) << n;
    endfunction

    function automatic agPkg::graphT randomGraph();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // even-parity nodes, none adjacent, so 64 components
    function automatic agPkg::graphT checkerboard();
        agPkg::graphT g;
        g = '0;
        for (int i = 0; i < agPkg::NodeCount; i++) begin
            g[i] = ($countones(i) % 2) == 0;
        end
        return g;
    endfunction

    task automatic sendTop(input agPkg::graphT t);
        for (int i = 0; i < agPkg::NodeCount; i++) begin
            @(posedge clk);
            #1 topChannel = {1'b1, t[i]};   // lsb first
        end
        @(posedge clk);
        #1 topChannel = 2'b00;
    endtask

    task automatic sendBot(input agPkg::graphT b, input logic last);
        @(posedge clk);
        #1;
        while (slowDown) begin
            botValid = 1'b0;
            @(posedge clk);
            #1;
        end
        botValid = 1'b1;
        bot = b;
        lastBotOfBatch = last;
    endtask

    task automatic endBots();
        @(posedge clk);
        #1 botValid = 1'b0;
        lastBotOfBatch = 1'b0;
    endtask

    task automatic singleGraph(input agPkg::graphT g);   // needs an all-ones top
        sendBot(~g, 1'b1);
        batchesSent++;
    endtask

    task automatic randomBatch(input int n);
        for (int k = 0; k < n; k++) begin
            sendBot(curTop & randomGraph(), k == n - 1);
        end
        batchesSent++;
    endtask

    task automatic denseBatch(input int n);
        for (int k = 0; k < n; k++) begin
            sendBot(randomGraph() & randomGraph() & randomGraph(), k == n - 1);
        end
        batchesSent++;
    endtask

    task automatic waitResults();
        wait (resultsSeen == batchesSent);
    endtask

    task automatic hardReset();
        repeat (2) @(posedge clk);  // let the flag check of the last batch finish
        #1 rstReq = 1'b1;
        @(posedge rstN);
        rstReq = 1'b0;
    endtask

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Timeout after %0d cycles, %0d of %0d batch results seen",
                 WatchdogCycles, resultsSeen, batchesSent);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(Seed));
        rstReq = 1'b0;
        longRst = 1'b0;
        topChannel = 2'b00;
        botValid = 1'b0;
        bot = '0;
        lastBotOfBatch = 1'b0;
        finalCheck = 1'b0;
        batchesSent = 0;
        @(posedge rstN);

        curTop = '1;
        sendTop(curTop);
        singleGraph(nodeBit(5));
        singleGraph(nodeBit(0) | nodeBit(1));
        singleGraph(nodeBit(0) | nodeBit(1) | nodeBit(3) | nodeBit(7));   // chain
        singleGraph(nodeBit(0) | nodeBit(1) | nodeBit(126) | nodeBit(127));
        singleGraph('0);
        endBots();

        curTop = randomGraph();
        sendTop(curTop);
        repeat (6) randomBatch(1 + int'($urandom() % 5));
        endBots();

        // dense graphs arrive faster than the flood fill drains them
        curTop = '1;
        sendTop(curTop);
        repeat (3) denseBatch(12);
        endBots();

        curTop = randomGraph() & ~nodeBit(0);   // node 0 left out for the bad bot
        sendTop(curTop);
        repeat (3) randomBatch(1 + int'($urandom() % 5));
        endBots();

        // longRst mid-batch, once the earlier terms are absorbed
        repeat (DrainBots) sendBot(curTop & randomGraph(), 1'b0);
        endBots();
        repeat (DrainBots * CyclesPerBot) @(posedge clk);
        #1 longRst = 1'b1;
        @(posedge clk);
        #1 longRst = 1'b0;
        randomBatch(2);
        endBots();

        sendBot((curTop & randomGraph()) | nodeBit(0), 1'b0);
        sendBot(curTop & randomGraph(), 1'b1);
        batchesSent++;
        endBots();
        waitResults();

        // flag cleared so the 64-component term has to raise it on its own
        hardReset();
        curTop = '1;
        sendTop(curTop);
        sendBot(~checkerboard(), 1'b0);
        sendBot(~nodeBit(9), 1'b1);
        batchesSent++;
        singleGraph(nodeBit(2) | nodeBit(3));   // flag must still be set here
        endBots();
        waitResults();

        // only a hard reset clears the flag
        hardReset();
        sendTop(curTop);
        singleGraph(nodeBit(64));
        endBots();
        waitResults();

        @(posedge clk);
        #1 finalCheck = 1'b1;
        @(posedge clk);
        #1 finalCheck = 1'b0;
        @(posedge clk);
        $display("Checks done: %0d value errors, %0d other errors, %0d results",
                 valueErrors, otherErrors, resultsSeen);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: test/pipelineChecker.sv
`timescale 1ns/1ps

module pipelineChecker #(
    parameter int PcoeffCountWidth = 10
) (
    input  logic clk,
    input  logic rstN,
    input  logic longRst,
    input  logic [1:0] topChannel,
    input  logic botValid,
    input  agPkg::graphT bot,
    input  logic lastBotOfBatch,
    input  logic slowDown,
    input  logic resultsValid,
    input  logic [PcoeffCountWidth+agPkg::PcoeffBits-1:0] pcoeffSum,
    input  logic [PcoeffCountWidth-1:0] pcoeffCount,
    input  logic errorFlag,
    input  logic finalCheck,
    output int resultsSeen,
    output int valueErrors,
    output int otherErrors
);

    localparam int SumWidth = PcoeffCountWidth + agPkg::PcoeffBits;

    agPkg::graphT ckTop;        // top as the DUT should hold it
    agPkg::graphT shiftTop;
    int strobes;
    longint unsigned runSum;
    int runCount;
    bit stickyFlag;
    int comps;
    longint unsigned expSum[$];
    int expCount[$];
    bit expFlag[$];             // flag state once the batch has passed
    bit flagMin;
    bit flagCheckDue;
    int slowCycles;
    longint unsigned wantSum;
    int wantCount;

    // breadth-first search over the hypercube neighbours
    function automatic int componentCount(agPkg::graphT g);
        agPkg::graphT seen;
        int q[$];
        int cur;
        int nb;
        int total;
        seen = '0;
        total = 0;
        for (int n = 0; n < agPkg::NodeCount; n++) begin
            if (g[n] && !seen[n]) begin
                total++;
                seen[n] = 1'b1;
                q.push_back(n);
                while (q.size() > 0) begin
                    cur = q.pop_front();
                    for (int d = 0; d < agPkg::Dim; d++) begin
                        nb = cur ^ (1 << d);
                        if (g[nb] && !seen[nb]) begin
                            seen[nb] = 1'b1;
                            q.push_back(nb);
                        end
                    end
                end
            end
        end
        return total;
    endfunction

    function automatic longint unsigned pcoeffTerm(int c);
        if (c > agPkg::MaxValidCount) begin
            return 0;
        end
        return 64'd1 << c;
    endfunction

    initial begin
        resultsSeen = 0;
        valueErrors = 0;
        otherErrors = 0;
        slowCycles = 0;
        flagCheckDue = 1'b0;
    end

    // input side, builds the expected batch totals
    always @(posedge clk) begin
        if (!rstN) begin
            ckTop = '0;
            shiftTop = '0;
            strobes = 0;
            runSum = 0;
            runCount = 0;
            stickyFlag = 1'b0;
            expSum.delete();
            expCount.delete();
            expFlag.delete();
        end else begin
            if (longRst) begin
                runSum = 0;     // earlier terms discarded
                runCount = 0;
            end
            if (botValid) begin
                comps = componentCount(ckTop & ~bot);
                if ((bot & ~ckTop) != '0 || comps > agPkg::MaxValidCount) begin
                    stickyFlag = 1'b1;
                end
                runSum += pcoeffTerm(comps);
                runCount++;
                if (lastBotOfBatch) begin
                    expSum.push_back(runSum);
                    expCount.push_back(runCount);
                    expFlag.push_back(stickyFlag);
                    runSum = 0;
                    runCount = 0;
                end
            end
            // a bot on the same edge still sees the old top
            if (topChannel[1]) begin
                shiftTop[strobes] = topChannel[0];
                strobes++;
                if (strobes == agPkg::NodeCount) begin
                    ckTop = shiftTop;
                    strobes = 0;
                end
            end
            if (slowDown) slowCycles++;
        end
    end

    // output side, sampled mid-cycle
    always @(negedge clk) begin
        if (!rstN) begin
            flagCheckDue = 1'b0;
        end else begin
            if (flagCheckDue) begin
                flagCheckDue = 1'b0;
                if (flagMin && !errorFlag) begin
                    valueErrors++;
                    $display("[ERROR] t=%0t errorFlag expected 1 got 0", $time);
                end else if (!stickyFlag && errorFlag) begin
                    valueErrors++;
                    $display("[ERROR] t=%0t errorFlag expected 0 got 1", $time);
                end
            end
            if (resultsValid) begin
                resultsSeen++;
                if (expSum.size() == 0) begin
                    otherErrors++;
                    $display("resultsValid at %0t with no batch outstanding", $time);
                end else begin
                    wantSum = expSum.pop_front();
                    wantCount = expCount.pop_front();
                    flagMin = expFlag.pop_front();
                    flagCheckDue = 1'b1;    // flag settles one cycle later
                    if (pcoeffSum !== SumWidth'(wantSum)) begin
                        valueErrors++;
                        $display("[ERROR] t=%0t pcoeffSum expected %0d got %0d",
                                 $time, wantSum, pcoeffSum);
                    end
                    if (pcoeffCount !== PcoeffCountWidth'(wantCount)) begin
                        valueErrors++;
                        $display("[ERROR] t=%0t pcoeffCount expected %0d got %0d",
                                 $time, wantCount, pcoeffCount);
                    end
                end
            end
        end
    end

    always @(posedge finalCheck) begin
        if (expSum.size() != 0) begin
            otherErrors++;
            $display("%0d batch results never arrived", expSum.size());
        end
        if (slowCycles == 0) begin
            otherErrors++;
            $display("slowDown was never asserted during the burst traffic");
        end
        if (errorFlag !== stickyFlag) begin
            valueErrors++;
            $display("[ERROR] t=%0t errorFlag expected %0d got %0d",
                     $time, stickyFlag, errorFlag);
        end
    end

endmodule

// File: test/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    input  logic rstReq,
    output logic clk,
    output logic rstN
);

    task automatic holdReset();
        rstN = 1'b0;
        repeat (3) @(posedge clk);   // low through three rising edges
        #1 rstN = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;       // 10 ns period
    end

    // power-on reset, then again on each request
    initial begin
        holdReset();
        forever begin
            @(posedge rstReq);
            holdReset();
        end
    end

endmodule
